// ==== src.f ====
src/cpuPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/alu.sv
src/fetchUnit.sv
src/stepControl.sv
src/cpuTop.sv
verification/clockGen.sv
verification/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and fail on a fail line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module cpuTb \
  -f src.f -o cpuSim &&
  ./obj_dir/cpuSim | tee sim.log &&
  test -s sim.log &&
  ! grep -q "test failed" sim.log ||
  { echo "simulation FAILED"; exit 1; }
echo "simulation OK"

// ==== verification/cpuTb.sv ====
// testbench top with program ROM, Wishbone memory model, directed tests and report
module cpuTb
  import cpuPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int haltTimeout = 2000;
  localparam int resetCycles = 16;

  logic   clk;
  logic   reset;
  pc_t    instrAddr;
  instr_t instr;
  logic   wbCyc;
  logic   wbStb;
  logic   wbWe;
  addr_t  wbAdr;
  data_t  wbDatOut;
  data_t  wbDatIn;
  logic   wbAck;
  logic   halted;

  instr_t rom [256];
  data_t  memory [256];
  addr_t  logAddr [$];
  data_t  logData [$];
  addr_t  expAddr [$];
  data_t  expData [$];
  pc_t    loadPc;
  int     testErrors;
  int     passedTests;
  int     failedTests;
  int unsigned lcgState = 93433;
  // memory model handshake state
  logic   busBusy;
  int unsigned ackWait;

  clockGen u_clockGen (
    .clk (clk)
  );

  cpuTop u_cpuTop (
    .clk       (clk),
    .reset     (reset),
    .instrAddr (instrAddr),
    .instr     (instr),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatOut  (wbDatOut),
    .wbDatIn   (wbDatIn),
    .wbAck     (wbAck),
    .halted    (halted)
  );

  // instruction port answers in the same cycle
  assign instr = rom[instrAddr];

  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState >> 16;
  endfunction

  function automatic instr_t setImm(data_t value);
    return {1'b0, value};
  endfunction

  function automatic instr_t encodeOp(opcode_t op, logic [1:0] arg);
    return {1'b1, op, arg};
  endfunction

  // odd multiplier gives every address its own byte
  function automatic data_t fillByte(int addr);
    return data_t'(addr * 37 + 11);
  endfunction

  // Wishbone slave with 0 to 3 extra wait cycles per access
  always @(posedge clk) begin
    if (reset) begin
      wbAck <= 1'b0;
      busBusy <= 1'b0;
      ackWait <= 0;
    end else if (wbAck) begin
      // master closes the cycle on this edge
      wbAck <= 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!busBusy) begin
        busBusy <= 1'b1;
        ackWait <= nextRandom() % 32'd4;
      end else if (ackWait != 0) begin
        ackWait <= ackWait - 1;
      end else begin
        busBusy <= 1'b0;
        wbAck <= 1'b1;
        if (wbWe) begin
          memory[wbAdr] = wbDatOut;
          logAddr.push_back(wbAdr);
          logData.push_back(wbDatOut);
        end else begin
          wbDatIn <= memory[wbAdr];
        end
      end
    end
  end

  task automatic startTest();
    for (int i = 0; i < 256; i++) begin
      rom[8'(i)] = encodeOp(opHalt, 2'd0);
      memory[8'(i)] = fillByte(i);
    end
    logAddr.delete();
    logData.delete();
    expAddr.delete();
    expData.delete();
    loadPc = '0;
    testErrors = 0;
  endtask

  task automatic emit(input instr_t word);
    rom[loadPc] = word;
    loadPc++;
  endtask

  task automatic expectWrite(input addr_t addr, input data_t data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic checkEqual(input string testName, input string what,
                            input data_t expected, input data_t actual);
    assert (actual == expected) else begin
      $display("Fail %s %s: expected 0x%02h, actual 0x%02h", testName, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic checkCount(input string testName, input string what,
                            input int expected, input int actual);
    assert (actual == expected) else begin
      $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
      testErrors++;
    end
  endtask

  // sampled on the falling edge away from register updates
  task automatic waitHalted(input string testName);
    int cycles;
    cycles = 0;
    while (!halted && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    assert (halted) else begin
      $display("%s: processor did not halt within %0d cycles", testName, haltTimeout);
      testErrors++;
    end
  endtask

  task automatic checkWrites(input string testName);
    checkCount(testName, "write count", expAddr.size(), logAddr.size());
    for (int i = 0; i < expAddr.size() && i < logAddr.size(); i++) begin
      checkEqual(testName, $sformatf("write %0d address", i), expAddr[i], logAddr[i]);
      checkEqual(testName, $sformatf("write %0d data", i), expData[i], logData[i]);
    end
  endtask

  task automatic endTest(input string testName);
    if (testErrors == 0) begin
      $display("%s: ok", testName);
      passedTests++;
    end else begin
      $display("%s: %0d errors", testName, testErrors);
      failedTests++;
    end
  endtask

  task automatic runProgram(input string testName);
    applyReset();
    waitHalted(testName);
    checkWrites(testName);
  endtask

  task automatic testSetStore();
    data_t sum;
    startTest();
    emit(setImm(8'h40));
    emit(encodeOp(opMov, 2'd1));
    emit(setImm(8'h5C));
    emit(encodeOp(opAdd1, 2'd0));
    // acc1 copied to $t3 and added back
    emit(encodeOp(opStr1, 2'd3));
    emit(encodeOp(opAdd1, 2'd3));
    emit(encodeOp(opStm1, 2'd1));
    emit(setImm(8'h41));
    emit(encodeOp(opMov, 2'd2));
    emit(encodeOp(opStm0, 2'd2));
    emit(encodeOp(opHalt, 2'd0));
    sum = 8'h5C;
    sum = sum + sum;
    expectWrite(8'h40, sum);
    expectWrite(8'h41, 8'h00);
    runProgram("setStore");
    endTest("setStore");
  endtask

  task automatic testLoadAll();
    data_t preset [$];
    startTest();
    for (int i = 0; i < 4; i++) begin
      preset.push_back(data_t'(nextRandom()));
      memory[8'h80 + 8'(i)] = preset[i];
    end
    emit(setImm(8'h80));
    emit(encodeOp(opLdm0, 2'd0));
    emit(setImm(8'h81));
    emit(encodeOp(opLdm1, 2'd0));
    emit(setImm(8'h82));
    emit(encodeOp(opLdm2, 2'd0));
    emit(setImm(8'h83));
    emit(encodeOp(opLdm3, 2'd0));
    // acc2 and acc3 loads must leave acc0 and acc1 alone
    emit(setImm(8'h90));
    emit(encodeOp(opStm0, 2'd0));
    emit(setImm(8'h91));
    emit(encodeOp(opStm1, 2'd0));
    emit(encodeOp(opHalt, 2'd0));
    expectWrite(8'h90, preset[0]);
    expectWrite(8'h91, preset[1]);
    runProgram("loadAll");
    endTest("loadAll");
  endtask

  task automatic testArithWrap();
    data_t acc;
    startTest();
    emit(setImm(8'hA0));
    emit(encodeOp(opMov, 2'd2));
    emit(setImm(8'hF0));
    emit(encodeOp(opAdd1, 2'd0));
    emit(setImm(8'h25));
    emit(encodeOp(opAdd1, 2'd0));
    emit(encodeOp(opStm1, 2'd2));
    emit(setImm(8'h40));
    emit(encodeOp(opSub1, 2'd0));
    emit(encodeOp(opStm1, 2'd2));
    emit(encodeOp(opDec1, 2'd0));
    emit(setImm(8'hD4));
    emit(encodeOp(opSub1, 2'd0));
    emit(encodeOp(opDec1, 2'd0));
    emit(encodeOp(opStm1, 2'd2));
    emit(encodeOp(opHalt, 2'd0));
    // wrap past 255 and then below 0 twice
    acc = 8'h00;
    acc = acc + 8'hF0;
    acc = acc + 8'h25;
    expectWrite(8'hA0, acc);
    acc = acc - 8'h40;
    expectWrite(8'hA0, acc);
    acc = acc - 8'd1;
    acc = acc - 8'hD4;
    acc = acc - 8'd1;
    expectWrite(8'hA0, acc);
    runProgram("arithWrap");
    endTest("arithWrap");
  endtask

  task automatic testShiftRight();
    data_t start;
    data_t signedOnce;
    start = 8'h96;
    startTest();
    emit(setImm(start));
    emit(encodeOp(opMov, 2'd1));
    emit(encodeOp(opMov, 2'd2));
    emit(encodeOp(opSrl, 2'd1));
    emit(encodeOp(opSra, 2'd2));
    emit(encodeOp(opAdd1, 2'd1));
    emit(setImm(8'hB0));
    emit(encodeOp(opMov, 2'd3));
    emit(encodeOp(opStm1, 2'd3));
    // back to zero and bring in the arithmetic result
    emit(encodeOp(opSub1, 2'd1));
    emit(encodeOp(opAdd1, 2'd2));
    emit(setImm(8'hB1));
    emit(encodeOp(opMov, 2'd3));
    emit(encodeOp(opStm1, 2'd3));
    emit(encodeOp(opSub1, 2'd2));
    emit(encodeOp(opSra, 2'd2));
    emit(encodeOp(opAdd1, 2'd2));
    emit(setImm(8'hB2));
    emit(encodeOp(opMov, 2'd3));
    emit(encodeOp(opStm1, 2'd3));
    emit(encodeOp(opHalt, 2'd0));
    // sign bit copied back in for the arithmetic form
    signedOnce = (start / 8'd2) | (start & 8'h80);
    expectWrite(8'hB0, start / 8'd2);
    expectWrite(8'hB1, signedOnce);
    expectWrite(8'hB2, (signedOnce / 8'd2) | (signedOnce & 8'h80));
    runProgram("shiftRight");
    endTest("shiftRight");
  endtask

  task automatic testBranchLoop(input int count);
    startTest();
    emit(setImm(8'hC0));
    emit(encodeOp(opMov, 2'd2));
    emit(setImm(data_t'(count)));
    emit(encodeOp(opAdd1, 2'd0));
    emit(encodeOp(opBnzr, 2'd0));
    // loop body at table entry 0
    loadPc = 8'd8;
    emit(encodeOp(opStm1, 2'd2));
    emit(encodeOp(opDec1, 2'd0));
    emit(encodeOp(opStr1, 2'd0));
    emit(encodeOp(opBnzr, 2'd1));
    emit(encodeOp(opHalt, 2'd0));
    // hop through the other entries back to the body
    loadPc = 8'd16;
    emit(encodeOp(opBnzr, 2'd2));
    loadPc = 8'd32;
    emit(encodeOp(opBnzr, 2'd3));
    loadPc = 8'd48;
    emit(encodeOp(opBnzr, 2'd0));
    for (int n = count; n > 0; n--) begin
      expectWrite(8'hC0, data_t'(n));
    end
    runProgram("branchLoop");
    endTest("branchLoop");
  endtask

  task automatic testHaltRandom();
    data_t loaded;
    startTest();
    loaded = fillByte(32'h20);
    emit(setImm(8'h20));
    emit(encodeOp(opLdm1, 2'd0));
    emit(setImm(8'h21));
    emit(encodeOp(opMov, 2'd1));
    emit(encodeOp(opStm1, 2'd1));
    emit(setImm(8'h07));
    emit(encodeOp(opAdd1, 2'd0));
    emit(encodeOp(opStm1, 2'd1));
    // opcode 111111 is not kept
    emit(9'h1FC);
    emit(encodeOp(opHalt, 2'd0));
    // never reached after halt
    emit(setImm(8'h22));
    emit(encodeOp(opStm1, 2'd0));
    expectWrite(8'h21, loaded);
    expectWrite(8'h21, loaded + 8'h07);
    runProgram("haltRandom");
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (halted && !wbCyc && !wbStb) else begin
        $display("haltRandom: halted dropped or a bus cycle opened after halt");
        testErrors++;
      end
    end
    checkEqual("haltRandom", "memory 0x20", fillByte(32'h20), memory[8'h20]);
    checkEqual("haltRandom", "memory 0x21", loaded + 8'h07, memory[8'h21]);
    checkEqual("haltRandom", "memory 0x22", fillByte(32'h22), memory[8'h22]);
    endTest("haltRandom");
  endtask

  initial begin
    reset <= 1'b1;
    wbAck <= 1'b0;
    wbDatIn <= '0;
    passedTests = 0;
    failedTests = 0;
    startTest();
    testSetStore();
    testLoadAll();
    testArithWrap();
    testShiftRight();
    testBranchLoop(5);
    testHaltRandom();
    $display("tests run %0d, ok %0d, with errors %0d",
             passedTests + failedTests, passedTests, failedTests);
    if (failedTests == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verification/clockGen.sv ====
// free-running testbench clock, 20 ns period
module clockGen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam realtime halfPeriod = 10ns;

  initial begin
    clk = 1'b0;
    forever begin
      #(halfPeriod) clk = ~clk;
    end
  end

endmodule

// ==== src/cpuTop.sv ====
// cpuTop: accumulator processor top with instruction read port and Wishbone data port
module cpuTop
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  output pc_t    instrAddr,
  input  instr_t instr,
  output logic   wbCyc,
  output logic   wbStb,
  output logic   wbWe,
  output addr_t  wbAdr,
  output data_t  wbDatOut,
  input  data_t  wbDatIn,
  input  logic   wbAck,
  output logic   halted
);

  ctrl_t ctrl;
  data_t readData1;
  data_t readData2;
  data_t aluResult;
  data_t memData;
  logic  isZero;
  logic  regWrite;
  logic  advance;

  instrDecoder u_instrDecoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // read1 feeds alu A and the bus address, read2 alu B and store data
  regFile u_regFile (
    .clk       (clk),
    .reset     (reset),
    .read1     (ctrl.read1),
    .read2     (ctrl.read2),
    .regWrite  (regWrite),
    .writeReg  (ctrl.writeReg),
    .wbSrc     (ctrl.wbSrc),
    .imm       (ctrl.imm),
    .aluResult (aluResult),
    .memData   (memData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  alu u_alu (
    .aluOp    (ctrl.aluOp),
    .operandA (readData1),
    .operandB (readData2),
    .result   (aluResult),
    .isZero   (isZero)
  );

  // pc drives the instruction port directly
  fetchUnit u_fetchUnit (
    .clk       (clk),
    .reset     (reset),
    .advance   (advance),
    .branch    (ctrl.branch),
    .branchSel (ctrl.branchSel),
    .isZero    (isZero),
    .pc        (instrAddr)
  );

  stepControl u_stepControl (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .address   (readData1),
    .storeData (readData2),
    .regWrite  (regWrite),
    .advance   (advance),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbDatOut  (wbDatOut),
    .wbDatIn   (wbDatIn),
    .wbAck     (wbAck),
    .memData   (memData),
    .halted    (halted)
  );

endmodule

// ==== src/stepControl.sv ====
// stepControl: execute/bus-wait/halted FSM, Wishbone classic master, write and advance strobes
module stepControl
  import cpuPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  ctrl_t ctrl,
  input  addr_t address,
  input  data_t storeData,
  output logic  regWrite,
  output logic  advance,
  output logic  wbCyc,
  output logic  wbStb,
  output logic  wbWe,
  output addr_t wbAdr,
  output data_t wbDatOut,
  input  data_t wbDatIn,
  input  logic  wbAck,
  output data_t memData,
  output logic  halted
);

  step_t state;
  logic  isMem;
  logic  busDone;

  assign isMem = ctrl.memRead | ctrl.memWrite;
  // ack seen while our cycle is open
  assign busDone = (state == stBusWait) && wbAck;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stExecute;
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe <= 1'b0;
    end else begin
      case (state)
        stExecute: begin
          if (ctrl.halt) begin
            state <= stHalted;
          end else if (isMem) begin
            // open bus cycle, request held until ack
            state <= stBusWait;
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe <= ctrl.memWrite;
          end
        end
        stBusWait: begin
          if (wbAck) begin
            // cyc and stb low from the next cycle
            state <= stExecute;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe <= 1'b0;
          end
        end
        default: begin
          // stay halted until reset
          state <= stHalted;
        end
      endcase
    end
  end

  // bus address and data, captured with the request
  always_ff @(posedge clk) begin
    if (state == stExecute && isMem) begin
      wbAdr <= address;
      wbDatOut <= storeData;
    end
  end

  // slave data valid with ack, written on the ack edge
  assign memData = busDone ? wbDatIn : '0;

  // strobes only in the completing cycle
  always_comb begin
    regWrite = 1'b0;
    advance = 1'b0;
    if (state == stExecute && !ctrl.halt && !isMem) begin
      regWrite = ctrl.writeEn;
      advance = 1'b1;
    end else if (busDone) begin
      regWrite = ctrl.writeEn;
      advance = 1'b1;
    end
  end

  assign halted = (state == stHalted);

endmodule

// ==== src/fetchUnit.sv ====
// fetchUnit: program counter with branch table lookup and next-address select
module fetchUnit
  import cpuPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       advance,
  input  logic       branch,
  input  logic [1:0] branchSel,
  input  logic       isZero,
  output pc_t        pc
);

  pc_t nextPc;

  // taken only when $t0 is non-zero
  always_comb begin
    if (branch && !isZero) begin
      nextPc = branchTable[branchSel];
    end else begin
      nextPc = pc + pc_t'(1);
    end
  end

  // pc holds while a bus access is pending or after halt
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (advance) begin
      pc <= nextPc;
    end
  end

endmodule

// ==== src/alu.sv ====
// alu: add, subtract, decrement, logical and arithmetic shift, pass, zero test
module alu
  import cpuPkg::*;
(
  input  aluOp_t aluOp,
  input  data_t  operandA,
  input  data_t  operandB,
  output data_t  result,
  output logic   isZero
);

  always_comb begin
    case (aluOp)
      // wraps modulo 256
      aluAdd: result = operandA + operandB;
      aluSub: result = operandA - operandB;
      aluDec: result = operandA - data_t'(1);
      // shifts act on operandA only
      aluSrl: result = operandA >> 1;
      aluSra: result = {operandA[dataWidth-1], operandA[dataWidth-1:1]};
      // mov and str1
      default: result = operandA;
    endcase
  end

  // bnzr reads $t0 on operandA
  assign isZero = (operandA == '0);

endmodule

// ==== src/regFile.sv ====
// regFile: four temporaries, six accumulators, writeback source mux, two read ports
module regFile
  import cpuPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  regSel_t read1,
  input  regSel_t read2,
  input  logic    regWrite,
  input  regSel_t writeReg,
  input  wbSrc_t  wbSrc,
  input  data_t   imm,
  input  data_t   aluResult,
  input  data_t   memData,
  output data_t   readData1,
  output data_t   readData2
);

  data_t temps [numTemps];
  data_t accs [numAccs];
  data_t writeData;

  // acc6 and acc7 do not exist, read as zero
  function automatic data_t readReg(regSel_t sel);
    data_t value;
    if (sel[3]) begin
      value = temps[sel[1:0]];
    end else if (sel[2:0] < 3'(numAccs)) begin
      value = accs[sel[2:0]];
    end else begin
      value = '0;
    end
    return value;
  endfunction

  always_comb begin
    readData1 = readReg(read1);
    readData2 = readReg(read2);
  end

  // write value select
  always_comb begin
    case (wbSrc)
      srcImm: writeData = imm;
      srcAlu: writeData = aluResult;
      srcMem: writeData = memData;
      default: writeData = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numTemps; i++) begin
        temps[i] <= '0;
      end
      for (int i = 0; i < numAccs; i++) begin
        accs[i] <= '0;
      end
    end else if (regWrite) begin
      if (writeReg[3]) begin
        temps[writeReg[1:0]] <= writeData;
      end else if (writeReg[2:0] < 3'(numAccs)) begin
        accs[writeReg[2:0]] <= writeData;
      end
    end
  end

endmodule

// ==== src/instrDecoder.sv ====
// combinational decode of a 9-bit instruction into a control word
module instrDecoder
  import cpuPkg::*;
(
  input  instr_t instr,
  output ctrl_t  ctrl
);

  opcode_t opcode;
  regSel_t argTemp;

  assign opcode = opcode_t'(instr[7:2]);
  // argument field always names a temporary
  assign argTemp = {2'b10, instr[1:0]};

  always_comb begin
    // all-inactive word is also the no-op result
    ctrl = '0;
    ctrl.wbSrc = srcZero;
    ctrl.aluOp = aluPass;
    if (!instr[8]) begin
      // set immediate into $t0
      ctrl.writeEn = 1'b1;
      ctrl.writeReg = selT0;
      ctrl.wbSrc = srcImm;
      ctrl.imm = instr[7:0];
    end else begin
      case (opcode)
        opLdm0, opLdm1, opLdm2, opLdm3: begin
          // accN from mem[$t_] with N in the opcode low bits
          ctrl.read1 = argTemp;
          ctrl.memRead = 1'b1;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = {2'b00, instr[3:2]};
          ctrl.wbSrc = srcMem;
        end
        opAdd1: begin
          ctrl.read1 = selAcc1;
          ctrl.read2 = argTemp;
          ctrl.aluOp = aluAdd;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = selAcc1;
          ctrl.wbSrc = srcAlu;
        end
        opSub1: begin
          ctrl.read1 = selAcc1;
          ctrl.read2 = argTemp;
          ctrl.aluOp = aluSub;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = selAcc1;
          ctrl.wbSrc = srcAlu;
        end
        opDec1: begin
          ctrl.read1 = selAcc1;
          ctrl.aluOp = aluDec;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = selAcc1;
          ctrl.wbSrc = srcAlu;
        end
        opStr1: begin
          // acc1 passes through the alu into $t_
          ctrl.read1 = selAcc1;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = argTemp;
          ctrl.wbSrc = srcAlu;
        end
        opMov: begin
          ctrl.read1 = selT0;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = argTemp;
          ctrl.wbSrc = srcAlu;
        end
        opStm0: begin
          // address on read1 and data on read2
          ctrl.read1 = argTemp;
          ctrl.read2 = selAcc0;
          ctrl.memWrite = 1'b1;
        end
        opStm1: begin
          ctrl.read1 = argTemp;
          ctrl.read2 = selAcc1;
          ctrl.memWrite = 1'b1;
        end
        opSrl, opSra: begin
          // shift $t_ in place
          ctrl.read1 = argTemp;
          ctrl.aluOp = (opcode == opSrl) ? aluSrl : aluSra;
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = argTemp;
          ctrl.wbSrc = srcAlu;
        end
        opBnzr: begin
          // $t0 on read1 for the zero test
          ctrl.read1 = selT0;
          ctrl.branch = 1'b1;
          ctrl.branchSel = instr[1:0];
        end
        opZero0: begin
          ctrl.writeEn = 1'b1;
          ctrl.writeReg = selAcc0;
          ctrl.wbSrc = srcZero;
        end
        opHalt: begin
          ctrl.halt = 1'b1;
        end
        default: begin
          // unknown opcodes stay inactive
        end
      endcase
    end
  end

endmodule

// ==== src/cpuPkg.sv ====
// shared widths, register selects, opcode/alu/writeback/state enums, control word, branch table
package cpuPkg;

  // datapath width
  localparam int dataWidth = 8;

  // register file sizes
  localparam int numTemps = 4;
  localparam int numAccs = 6;

  typedef logic [dataWidth-1:0] data_t;
  typedef logic [7:0] addr_t;
  typedef logic [7:0] pc_t;
  typedef logic [8:0] instr_t;

  // bit 3 set selects a temporary, clear an accumulator
  typedef logic [3:0] regSel_t;

  // fixed register selects used by the decoder
  localparam regSel_t selT0 = 4'b1000;
  localparam regSel_t selAcc0 = 4'b0000;
  localparam regSel_t selAcc1 = 4'b0001;

  // kept opcodes, instr[7:2] when instr[8] is set
  typedef enum logic [5:0] {
    opLdm0  = 6'b000000,
    opLdm1  = 6'b000001,
    opLdm2  = 6'b000010,
    opLdm3  = 6'b000011,
    opAdd1  = 6'b001000,
    opSub1  = 6'b001101,
    opStr1  = 6'b010010,
    opStm0  = 6'b010101,
    opStm1  = 6'b010110,
    opMov   = 6'b011010,
    opSrl   = 6'b011011,
    opSra   = 6'b011100,
    opBnzr  = 6'b011110,
    opDec1  = 6'b100001,
    opZero0 = 6'b100010,
    opHalt  = 6'b110110
  } opcode_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluDec,
    aluSrl,
    aluSra,
    aluPass
  } aluOp_t;

  // register write source
  typedef enum logic [1:0] {
    srcZero,
    srcImm,
    srcAlu,
    srcMem
  } wbSrc_t;

  // decoded control word, one per instruction
  typedef struct packed {
    regSel_t    read1;
    regSel_t    read2;
    logic       writeEn;
    regSel_t    writeReg;
    wbSrc_t     wbSrc;
    aluOp_t     aluOp;
    data_t      imm;
    logic       memRead;
    logic       memWrite;
    logic       branch;
    logic [1:0] branchSel;
    logic       halt;
  } ctrl_t;

  typedef enum logic [1:0] {
    stExecute,
    stBusWait,
    stHalted
  } step_t;

  // bnzr targets, entry 0 in the low byte
  localparam pc_t [3:0] branchTable = {8'd48, 8'd32, 8'd16, 8'd8};

endpackage
